//--- src/vfpu_pkg.sv
/* Shared widths, lane count, operator and lane op codes, FP16 NaN constant */

`default_nettype none

package vfpu_pkg;

    //--------------------------------------------------
    // Datapath widths
    //--------------------------------------------------
    localparam int unsigned FLEN      = 64;      // Vector operand and result width
    localparam int unsigned LANE_W    = 16;      // One FP16 element
    localparam int unsigned NUM_LANES = 4;
    localparam int unsigned EXP_W     = 5;       // FP16 exponent
    localparam int unsigned MAN_W     = 10;      // FP16 mantissa
    localparam int unsigned TAG_W     = 3;       // Transaction id

    //--------------------------------------------------
    // External operator codes
    //--------------------------------------------------
    localparam int unsigned OPER_W = 4;
    localparam logic [OPER_W-1:0] OP_VFMIN   = 4'd0;
    localparam logic [OPER_W-1:0] OP_VFMAX   = 4'd1;
    localparam logic [OPER_W-1:0] OP_VFSGNJ  = 4'd2;
    localparam logic [OPER_W-1:0] OP_VFSGNJN = 4'd3;
    localparam logic [OPER_W-1:0] OP_VFSGNJX = 4'd4;
    localparam logic [OPER_W-1:0] OP_VFEQ    = 4'd5;
    localparam logic [OPER_W-1:0] OP_VFNE    = 4'd6;    // Inverted EQ
    localparam logic [OPER_W-1:0] OP_VFLT    = 4'd7;
    localparam logic [OPER_W-1:0] OP_VFGE    = 4'd8;    // Inverted LT
    localparam logic [OPER_W-1:0] OP_VFLE    = 4'd9;
    localparam logic [OPER_W-1:0] OP_VFGT    = 4'd10;   // Inverted LE

    // Lane operation groups
    localparam int unsigned LOP_W = 2;
    localparam logic [LOP_W-1:0] LOP_MINMAX = 2'd0;
    localparam logic [LOP_W-1:0] LOP_SGNJ   = 2'd1;
    localparam logic [LOP_W-1:0] LOP_CMP    = 2'd2;

    localparam logic [LANE_W-1:0] CANON_NAN = 16'h7E00;  // Quiet NaN, positive sign

endpackage

`default_nettype wire

//--- src/vfpu_stage_if.sv
/* Decoded vector operation passed from issue to the lanes, load from writeback */

`timescale 1ns/10ps
`default_nettype none

interface vfpu_stage_if;

    logic                             op_valid;   // Issue offers an operation
    logic [vfpu_pkg::LOP_W-1:0]       lane_op;    // MINMAX, SGNJ or CMP
    logic                             op_mod;     // Inverts compare result
    logic [1:0]                       lane_sel;   // Sub-operation within the group
    logic [vfpu_pkg::FLEN-1:0]        operand_a;
    logic [vfpu_pkg::FLEN-1:0]        operand_b;  // Already replicated if requested
    logic [vfpu_pkg::TAG_W-1:0]       tag;
    logic                             load;       // Stage 1 takes a new item

    modport issue (output op_valid, lane_op, op_mod, lane_sel, operand_a, operand_b, tag,
                   input  load);

    modport wb    (input  op_valid, tag,
                   output load);

    modport lane  (input  lane_op, op_mod, lane_sel, operand_a, operand_b, load);

endinterface

`default_nettype wire

//--- src/vfpu_issue.sv
/* Operator decode, scalar replication of operand B and READY/STALL hold buffer */

`timescale 1ns/10ps
`default_nettype none

module vfpu_issue (
    input  wire logic                           clk_i,
    input  wire logic                           rst_ni,
    input  wire logic                           flush_i,
    input  wire logic                           valid_i,
    output logic                                ready_o,
    input  wire logic [vfpu_pkg::OPER_W-1:0]    operator_i,
    input  wire logic                           rep_i,
    input  wire logic [vfpu_pkg::FLEN-1:0]      operand_a_i,
    input  wire logic [vfpu_pkg::FLEN-1:0]      operand_b_i,
    input  wire logic [vfpu_pkg::TAG_W-1:0]     trans_id_i,
    vfpu_stage_if.issue                         stage
);

    // Decoded word, live (_d) and held (_q)
    logic [vfpu_pkg::LOP_W-1:0]  lane_op_d,   lane_op_q;
    logic                        op_mod_d,    op_mod_q;
    logic [1:0]                  lane_sel_d,  lane_sel_q;
    logic [vfpu_pkg::FLEN-1:0]   operand_b_d, operand_b_q;
    logic [vfpu_pkg::FLEN-1:0]   operand_a_q;
    logic [vfpu_pkg::TAG_W-1:0]  tag_q;

    logic stall_d, stall_q;  // 0 = READY, 1 = STALL
    logic hold;              // Capture into hold buffer
    logic use_hold;          // Present held word to the lanes

    //--------------------------------------------------
    // Decode
    //--------------------------------------------------
    always_comb begin : decode
        lane_op_d  = vfpu_pkg::LOP_SGNJ;   // Unknown codes act as VFSGNJ
        op_mod_d   = 1'b0;
        lane_sel_d = 2'd0;
        case (operator_i)
            vfpu_pkg::OP_VFMIN:   lane_op_d = vfpu_pkg::LOP_MINMAX;
            vfpu_pkg::OP_VFMAX: begin
                lane_op_d  = vfpu_pkg::LOP_MINMAX;
                lane_sel_d = 2'd1;              // max
            end
            vfpu_pkg::OP_VFSGNJN: lane_sel_d = 2'd1;
            vfpu_pkg::OP_VFSGNJX: lane_sel_d = 2'd2;
            vfpu_pkg::OP_VFEQ, vfpu_pkg::OP_VFNE: begin
                lane_op_d  = vfpu_pkg::LOP_CMP;
                lane_sel_d = 2'd2;              // eq
                op_mod_d   = (operator_i == vfpu_pkg::OP_VFNE);
            end
            vfpu_pkg::OP_VFLT, vfpu_pkg::OP_VFGE: begin
                lane_op_d  = vfpu_pkg::LOP_CMP;
                lane_sel_d = 2'd1;              // lt
                op_mod_d   = (operator_i == vfpu_pkg::OP_VFGE);
            end
            vfpu_pkg::OP_VFLE, vfpu_pkg::OP_VFGT: begin
                lane_op_d  = vfpu_pkg::LOP_CMP; // le, lane_sel stays 0
                op_mod_d   = (operator_i == vfpu_pkg::OP_VFGT);
            end
            default: ;                          // VFSGNJ and unknown
        endcase
    end

    // Scalar in lane 0 of B broadcast to every lane
    assign operand_b_d = rep_i ? {vfpu_pkg::NUM_LANES{operand_b_i[vfpu_pkg::LANE_W-1:0]}}
                               : operand_b_i;

    //--------------------------------------------------
    // Protocol inversion FSM
    //--------------------------------------------------
    always_comb begin : hold_fsm
        ready_o        = 1'b0;
        stage.op_valid = 1'b0;
        hold           = 1'b0;
        use_hold       = 1'b0;
        stall_d        = stall_q;
        if (!stall_q) begin
            ready_o        = 1'b1;
            stage.op_valid = valid_i;       // Pass straight through
            if (valid_i && !stage.load) begin
                ready_o = 1'b0;             // Take it into the buffer instead
                hold    = 1'b1;
                stall_d = 1'b1;
            end
        end else begin
            stage.op_valid = 1'b1;          // Held item waits for load
            use_hold       = 1'b1;
            if (stage.load) begin
                ready_o = 1'b1;             // Token back, valid_i not forwarded
                stall_d = 1'b0;
            end
        end
        if (flush_i) stall_d = 1'b0;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= stall_d;
        end
    end

    // Hold buffer payload
    always_ff @(posedge clk_i) begin
        if (hold) begin
            lane_op_q   <= lane_op_d;
            op_mod_q    <= op_mod_d;
            lane_sel_q  <= lane_sel_d;
            operand_a_q <= operand_a_i;
            operand_b_q <= operand_b_d;
            tag_q       <= trans_id_i;
        end
    end

    // Lanes see held word in STALL
    assign stage.lane_op   = use_hold ? lane_op_q   : lane_op_d;
    assign stage.op_mod    = use_hold ? op_mod_q    : op_mod_d;
    assign stage.lane_sel  = use_hold ? lane_sel_q  : lane_sel_d;
    assign stage.operand_a = use_hold ? operand_a_q : operand_a_i;
    assign stage.operand_b = use_hold ? operand_b_q : operand_b_d;
    assign stage.tag       = use_hold ? tag_q       : trans_id_i;

endmodule

`default_nettype wire

//--- src/vfpu_lane.sv
/* One FP16 lane: min/max, sign injection or compare, result and NV registered on load */

`timescale 1ns/10ps
`default_nettype none

module vfpu_lane #(
    parameter int unsigned LANE = 0     // Position within the vector
) (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    vfpu_stage_if.lane                        stage,
    output logic [vfpu_pkg::LANE_W-1:0]       res_o,
    output logic                              nv_o
);

    localparam int unsigned W = vfpu_pkg::LANE_W;

    logic [W-1:0] a, b;
    logic         sign_a, sign_b;
    logic         a_nan, b_nan, a_snan, b_snan, any_nan;
    logic         both_zero;
    logic         lt_tot;       // Total order, -0 below +0
    logic         eq, lt, le;   // IEEE compare, +0 == -0
    logic         cmp_bit;
    logic [W-1:0] res_d;
    logic         nv_d;

    assign a = stage.operand_a[LANE*W +: W];
    assign b = stage.operand_b[LANE*W +: W];

    assign sign_a = a[W-1];
    assign sign_b = b[W-1];

    // NaN: exponent all ones, mantissa nonzero; signaling when quiet bit clear
    assign a_nan  = (&a[W-2 -: vfpu_pkg::EXP_W]) && (|a[vfpu_pkg::MAN_W-1:0]);
    assign b_nan  = (&b[W-2 -: vfpu_pkg::EXP_W]) && (|b[vfpu_pkg::MAN_W-1:0]);
    assign a_snan = a_nan && !a[vfpu_pkg::MAN_W-1];
    assign b_snan = b_nan && !b[vfpu_pkg::MAN_W-1];
    assign any_nan = a_nan || b_nan;

    assign both_zero = (a[W-2:0] == '0) && (b[W-2:0] == '0);

    // Sign-magnitude ordering
    assign lt_tot = (sign_a != sign_b) ? sign_a
                  : (sign_a ? (a[W-2:0] > b[W-2:0]) : (a[W-2:0] < b[W-2:0]));
    assign eq = (a == b) || both_zero;
    assign lt = lt_tot && !both_zero;
    assign le = lt || eq;

    //--------------------------------------------------
    // Operation select
    //--------------------------------------------------
    always_comb begin : lane_op
        res_d   = a;
        nv_d    = 1'b0;
        cmp_bit = 1'b0;
        case (stage.lane_op)
            vfpu_pkg::LOP_MINMAX: begin
                nv_d = a_snan || b_snan;
                if (a_nan && b_nan)  res_d = vfpu_pkg::CANON_NAN;
                else if (a_nan)      res_d = b;   // NaN loses to a number
                else if (b_nan)      res_d = a;
                else if (stage.lane_sel[0]) res_d = lt_tot ? b : a; // max
                else                 res_d = lt_tot ? a : b;        // min
            end
            vfpu_pkg::LOP_CMP: begin
                case (stage.lane_sel)
                    2'd2: begin                 // eq, quiet
                        cmp_bit = eq && !any_nan;
                        nv_d    = a_snan || b_snan;
                    end
                    2'd1: begin                 // lt, signaling
                        cmp_bit = lt && !any_nan;
                        nv_d    = any_nan;
                    end
                    default: begin              // le, signaling
                        cmp_bit = le && !any_nan;
                        nv_d    = any_nan;
                    end
                endcase
                res_d = {{(W-1){1'b0}}, cmp_bit ^ stage.op_mod};
            end
            default: begin                      // Sign injection, never NV
                case (stage.lane_sel)
                    2'd1:    res_d = {~sign_b, a[W-2:0]};
                    2'd2:    res_d = {sign_a ^ sign_b, a[W-2:0]};
                    default: res_d = {sign_b, a[W-2:0]};
                endcase
            end
        endcase
    end

    // Stage 1 registers
    always_ff @(posedge clk_i) begin
        if (stage.load) res_o <= res_d;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nv_o <= 1'b0;
        end else if (stage.load) begin
            nv_o <= nv_d;
        end
    end

endmodule

`default_nettype wire

//--- src/vfpu_writeback.sv
/* Stage 1 valid/tag tracking, output register with back-pressure, lane merge and NV OR */

`timescale 1ns/10ps
`default_nettype none

module vfpu_writeback (
    input  wire logic                                 clk_i,
    input  wire logic                                 rst_ni,
    input  wire logic                                 flush_i,
    vfpu_stage_if.wb                                  stage,
    input  wire logic [vfpu_pkg::LANE_W-1:0]          lane_res_i [vfpu_pkg::NUM_LANES],
    input  wire logic [vfpu_pkg::NUM_LANES-1:0]       lane_nv_i,
    input  wire logic                                 result_ready_i,
    output logic                                      valid_o,
    output logic [vfpu_pkg::FLEN-1:0]                 result_o,
    output logic [vfpu_pkg::TAG_W-1:0]                trans_id_o,
    output logic                                      nv_o
);

    logic                        s1_valid_q;     // Lane registers hold an item
    logic [vfpu_pkg::TAG_W-1:0]  s1_tag_q;
    logic                        out_valid_q;
    logic [vfpu_pkg::FLEN-1:0]   result_q;
    logic [vfpu_pkg::TAG_W-1:0]  tag_q;
    logic                        nv_q;
    logic                        out_free;       // Output register can take data
    logic                        s1_move;        // Stage 1 item advances
    logic [vfpu_pkg::FLEN-1:0]   lane_cat;
    logic                        nv_any;

    assign out_free   = !out_valid_q || result_ready_i;
    assign s1_move    = s1_valid_q && out_free;
    assign stage.load = !s1_valid_q || s1_move;

    // Merge lanes, lane 0 in the low bits
    always_comb begin : merge
        for (int i = 0; i < vfpu_pkg::NUM_LANES; i++) begin
            lane_cat[i*vfpu_pkg::LANE_W +: vfpu_pkg::LANE_W] = lane_res_i[i];
        end
        nv_any = |lane_nv_i;   // Any lane invalid
    end

    //--------------------------------------------------
    // Valid tracking
    //--------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q  <= 1'b0;
            out_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q  <= 1'b0;   // Drop everything in flight
            out_valid_q <= 1'b0;
        end else begin
            if (stage.load) s1_valid_q  <= stage.op_valid;
            if (out_free)   out_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage.load && stage.op_valid) s1_tag_q <= stage.tag;
        if (s1_move) begin
            result_q <= lane_cat;
            tag_q    <= s1_tag_q;
            nv_q     <= nv_any;
        end
    end

    assign valid_o    = out_valid_q;
    assign result_o   = result_q;
    assign trans_id_o = tag_q;
    assign nv_o       = nv_q;

endmodule

`default_nettype wire

//--- src/vfpu_top.sv
/* Vector FP16 unit top: issue stage, four lanes and writeback */

`timescale 1ns/10ps
`default_nettype none

module vfpu_top (
    input  wire logic                           clk_i,
    input  wire logic                           rst_ni,
    input  wire logic                           flush_i,
    input  wire logic                           valid_i,
    output logic                                ready_o,
    input  wire logic [vfpu_pkg::OPER_W-1:0]    operator_i,
    input  wire logic                           rep_i,
    input  wire logic [vfpu_pkg::FLEN-1:0]      operand_a_i,
    input  wire logic [vfpu_pkg::FLEN-1:0]      operand_b_i,
    input  wire logic [vfpu_pkg::TAG_W-1:0]     trans_id_i,
    input  wire logic                           result_ready_i,
    output logic                                valid_o,
    output logic [vfpu_pkg::FLEN-1:0]           result_o,
    output logic [vfpu_pkg::TAG_W-1:0]          trans_id_o,
    output logic                                nv_o
);

    logic [vfpu_pkg::LANE_W-1:0]    lane_res [vfpu_pkg::NUM_LANES];  // Stage 1 results
    logic [vfpu_pkg::NUM_LANES-1:0] lane_nv;

    vfpu_stage_if stage ();

    vfpu_issue u_issue (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .valid_i     (valid_i),
        .ready_o     (ready_o),
        .operator_i  (operator_i),
        .rep_i       (rep_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .trans_id_i  (trans_id_i),
        .stage       (stage.issue)
    );

    //--------------------------------------------------
    // Lanes
    //--------------------------------------------------
    for (genvar g = 0; g < vfpu_pkg::NUM_LANES; g++) begin : gen_lane
        vfpu_lane #(.LANE(g)) u_lane (
            .clk_i  (clk_i),
            .rst_ni (rst_ni),
            .stage  (stage.lane),
            .res_o  (lane_res[g]),
            .nv_o   (lane_nv[g])
        );
    end

    vfpu_writeback u_wb (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .stage          (stage.wb),
        .lane_res_i     (lane_res),
        .lane_nv_i      (lane_nv),
        .result_ready_i (result_ready_i),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .trans_id_o     (trans_id_o),
        .nv_o           (nv_o)
    );

endmodule

`default_nettype wire

//--- verification/vfpu_assert.sv
/* Concurrent checks on output hold, flush and post-reset state, bound into vfpu_top */

`timescale 1ns/10ps
`default_nettype none

module vfpu_assert (
    input  wire logic                          clk_i,
    input  wire logic                          rst_ni,
    input  wire logic                          flush_i,
    input  wire logic                          ready_o,
    input  wire logic                          result_ready_i,
    input  wire logic                          valid_o,
    input  wire logic [vfpu_pkg::FLEN-1:0]     result_o,
    input  wire logic [vfpu_pkg::TAG_W-1:0]    trans_id_o
);

    // Output register frozen while the consumer stalls
    property result_held;
        @(posedge clk_i) disable iff (!rst_ni)
        (valid_o && !result_ready_i && !flush_i) |=>
            ($stable(valid_o) && $stable(result_o) && $stable(trans_id_o));
    endproperty

    // Nothing survives a flush
    property flush_clears;
        @(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !valid_o;
    endproperty

    // First cycle out of reset, empty pipe and open input
    property reset_state;
        @(posedge clk_i) $rose(rst_ni) |-> (ready_o && !valid_o);
    endproperty

    a_result_held: assert property (result_held)
        else $error("Result changed while held under back-pressure");
    a_flush_clears: assert property (flush_clears)
        else $error("valid_o high in the cycle after flush");
    a_reset_state: assert property (reset_state)
        else $error("ready_o low or valid_o high right after reset");

endmodule

`default_nettype wire

//--- verification/tb_vfpu_top.sv
/* Trace-driven testbench for vfpu_top with random result back-pressure, flush and ordered checking */

`timescale 1ns/10ps
`default_nettype none

module tb_vfpu_top;

    logic                          clk_i;
    logic                          rst_ni;
    logic                          flush_i;
    logic                          valid_i;
    logic                          ready_o;
    logic [vfpu_pkg::OPER_W-1:0]   operator_i;
    logic                          rep_i;
    logic [vfpu_pkg::FLEN-1:0]     operand_a_i;
    logic [vfpu_pkg::FLEN-1:0]     operand_b_i;
    logic [vfpu_pkg::TAG_W-1:0]    trans_id_i;
    logic                          result_ready_i;
    logic                          valid_o;
    logic [vfpu_pkg::FLEN-1:0]     result_o;
    logic [vfpu_pkg::TAG_W-1:0]    trans_id_o;
    logic                          nv_o;

    // One trace entry per data line
    logic                          tr_kind [$];   // 1 = flush marker
    logic [vfpu_pkg::OPER_W-1:0]   tr_op [$];
    logic                          tr_rep [$];
    logic [vfpu_pkg::FLEN-1:0]     tr_a [$];
    logic [vfpu_pkg::FLEN-1:0]     tr_b [$];
    logic [vfpu_pkg::TAG_W-1:0]    tr_tag [$];
    logic [vfpu_pkg::FLEN-1:0]     tr_res [$];
    logic                          tr_nv [$];

    int          exp_idx_q [$];    // Trace index of each accepted item in acceptance order
    logic [31:0] rnd = 32'd26;     // xorshift state
    int          cycle_count = 0;
    int          cycle_limit = 0;  // Set once the trace length is known

    vfpu_top UUT (.*);

    bind vfpu_top vfpu_assert u_assert (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .ready_o        (ready_o),
        .result_ready_i (result_ready_i),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .trans_id_o     (trans_id_o)
    );

    initial begin : clock
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;   // 40 ns period
    end

    //--------------------------------------------------
    // Helpers
    //--------------------------------------------------
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic abort_run(input string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_trace();
        int               fd;
        int               n;
        logic [8*128-1:0] header;
        logic [63:0]      f_kind, f_op, f_rep, f_a, f_b, f_tag, f_res, f_nv;
        fd = $fopen("verification/vfpu_trace.txt", "r");
        if (fd == 0) abort_run("could not open verification/vfpu_trace.txt");
        n = $fgets(header, fd);        // Two lines of column description
        n = $fgets(header, fd);
        n = 8;
        while (n == 8) begin
            n = $fscanf(fd, " %h %h %h %h %h %h %h %h",
                        f_kind, f_op, f_rep, f_a, f_b, f_tag, f_res, f_nv);
            if (n == 8) begin
                tr_kind.push_back(f_kind[0]);
                tr_op.push_back(f_op[vfpu_pkg::OPER_W-1:0]);
                tr_rep.push_back(f_rep[0]);
                tr_a.push_back(f_a);
                tr_b.push_back(f_b);
                tr_tag.push_back(f_tag[vfpu_pkg::TAG_W-1:0]);
                tr_res.push_back(f_res);
                tr_nv.push_back(f_nv[0]);
            end else if (n > 0) begin
                abort_run("malformed line in the trace file");
            end
        end
        $fclose(fd);
        if (tr_kind.size() == 0) abort_run("trace file holds no operations");
    endtask

    // Pop the oldest accepted item and compare it with the output port
    task automatic check_output();
        int k;
        if (exp_idx_q.size() == 0) begin
            abort_run($sformatf("result with tag %0d came out with nothing outstanding",
                                trans_id_o));
        end
        k = exp_idx_q.pop_front();
        compare_value(trans_id_o, tr_tag[k], $sformatf("trace line %0d tag", k + 1));
        compare_value(result_o, tr_res[k], $sformatf("trace line %0d result", k + 1));
        compare_value(nv_o, tr_nv[k], $sformatf("trace line %0d NV flag", k + 1));
    endtask

    //--------------------------------------------------
    // Stimulus and checking
    //--------------------------------------------------
    initial begin : run
        int   idx;
        logic do_flush;
        logic do_offer;
        logic stalled;              // Model of the issue READY/STALL state
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        valid_i        = 1'b0;
        operator_i     = '0;
        rep_i          = 1'b0;
        operand_a_i    = '0;
        operand_b_i    = '0;
        trans_id_i     = '0;
        result_ready_i = 1'b0;
        idx            = 0;
        stalled        = 1'b0;
        load_trace();
        cycle_limit = 20 * tr_kind.size() + 100;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;

        while (idx < tr_kind.size() || exp_idx_q.size() != 0 || stalled) begin
            @(posedge clk_i);
            rnd            = next_random(rnd);
            do_flush       = 1'b0;
            do_offer       = 1'b0;
            flush_i        <= 1'b0;
            valid_i        <= 1'b0;
            result_ready_i <= rnd[0];           // Roughly half the cycles stall
            if (idx < tr_kind.size()) begin
                if (tr_kind[idx]) begin
                    do_flush       = 1'b1;
                    flush_i        <= 1'b1;
                    result_ready_i <= 1'b0;     // No output handshake on the flush edge
                end else if (!stalled) begin
                    do_offer    = 1'b1;
                    valid_i     <= 1'b1;
                    operator_i  <= tr_op[idx];
                    rep_i       <= tr_rep[idx];
                    operand_a_i <= tr_a[idx];
                    operand_b_i <= tr_b[idx];
                    trans_id_i  <= tr_tag[idx];
                end
            end

            @(negedge clk_i);                   // Outputs settled for the coming edge
            // Both stages full and the output stalled means no load
            if (stalled) begin
                compare_value(ready_o, !(exp_idx_q.size() == 3 && !result_ready_i),
                              "ready_o with an item in the hold buffer");
            end else begin
                compare_value(ready_o, !(do_offer && exp_idx_q.size() == 2 && !result_ready_i),
                              "ready_o in READY");
            end
            if (valid_o && result_ready_i) begin
                check_output();
            end
            if (do_flush) begin
                exp_idx_q.delete();             // In-flight items are lost
                stalled = 1'b0;
                idx++;
            end else if (do_offer) begin
                exp_idx_q.push_back(idx);       // Accepted whether direct or captured
                stalled = !ready_o;             // ready_o low means it went to the buffer
                idx++;
            end else if (stalled && ready_o) begin
                stalled = 1'b0;                 // Held item loads on the next edge
            end
        end

        // Any result in these idle cycles is a duplicate
        repeat (8) begin
            @(posedge clk_i);
            result_ready_i <= 1'b1;
            @(negedge clk_i);
            if (valid_o) abort_run("extra result after every item was checked");
        end

        $display("SIMULATION PASSED");
        $finish;
    end

    always @(posedge clk_i) begin : watchdog
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("TIMEOUT: run did not finish within %0d clock cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

//--- vfpu_top.f
src/vfpu_pkg.sv
src/vfpu_stage_if.sv
src/vfpu_issue.sv
src/vfpu_lane.sv
src/vfpu_writeback.sv
src/vfpu_top.sv
verification/vfpu_assert.sv
verification/tb_vfpu_top.sv

//--- verification/vfpu_trace.txt
# kind(0 op, 1 flush) operator rep operand_a operand_b tag expected_result expected_nv
# all fields hex, lane 0 in the low 16 bits of each operand and result
0 0 0 3c00bc0000004000 bc003c008000c000 1 bc00bc008000c000 0
0 1 0 3c00bc0000004000 bc003c008000c000 2 3c003c0000004000 0
0 0 0 7e007e003c007c01 7e0040007e003800 3 7e0040003c003800 1
0 1 0 42007e00fe00c000 7e007e003c00c200 4 42007e003c00c000 0
0 1 0 38007c0080003c00 3e00fc000000fc01 5 3e007c0000003c00 1
0 2 0 3c00bc007e004000 80000000fc013c00 6 bc003c00fe004000 0
0 3 0 3c00bc007e004000 80000000fc013c00 7 3c00bc007e00c000 0
0 4 0 3c00bc007e004000 80000000fc013c00 0 bc00bc00fe004000 0
0 5 0 7c017e0000003c00 3c007e0080003c00 1 0000000000010001 1
0 5 0 40007e0000003c00 42007e0080003c00 2 0000000000010001 0
0 6 0 7c017e0000003c00 3c007e0080003c00 3 0001000100000000 1
0 7 0 7e008000bc003c00 3c0000003c004000 4 0000000000010001 1
0 7 0 c20040003c00c000 c00040003800bc00 5 0001000000000001 0
0 8 0 c20040003c00c000 c00040003800bc00 6 0000000100010000 0
0 9 0 3c00800040003c00 7e0000003c003c00 7 0000000100000001 1
0 a 0 3c00800040003c00 7e0000003c003c00 0 0001000000010000 1
0 8 0 0000000000007c01 0000000000003c00 1 0001000100010001 1
0 1 1 c0003c0042000000 7e007e007e003e00 2 3e003e0042003e00 0
0 2 1 4000400040004000 0000000000008000 3 c000c000c000c000 0
0 7 1 42003c0038000000 0000000000003c00 4 0000000000010001 0
0 f 0 3c003c003c003c00 8000000080000000 5 bc003c00bc003c00 0
1 0 0 0000000000000000 0000000000000000 0 0000000000000000 0
0 0 0 4000400040004000 3c003c003c003c00 6 3c003c003c003c00 0
0 5 0 123412341234abcd 123412341234abcd 7 0001000100010001 0
0 4 0 c000400000003c00 8000800080008000 0 4000c0008000bc00 0
1 0 0 0000000000000000 0000000000000000 0 0000000000000000 0
0 1 0 0000000000000000 8000800080008000 1 0000000000000000 0
0 6 0 3c003c003c003c00 3c003c004000bc00 2 0000000000010001 0
